//--- hdl/rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// register and datapath width, one word
`define RV_DATA_W 32
// word address bits of each memory, pc carries two more
`define RV_ADDR_W 10

// major opcodes of the supported subset
`define RV_OP_OP     7'b0110011
`define RV_OP_OP_IMM 7'b0010011
`define RV_OP_LOAD   7'b0000011
`define RV_OP_STORE  7'b0100011
`define RV_OP_BRANCH 7'b1100011
`define RV_OP_JAL    7'b1101111
`define RV_OP_LUI    7'b0110111
`define RV_OP_AUIPC  7'b0010111

// funct3 of the alu group, shared by reg and imm forms
`define RV_F3_ADD  3'b000
`define RV_F3_SLL  3'b001
`define RV_F3_SLT  3'b010
`define RV_F3_SLTU 3'b011
`define RV_F3_XOR  3'b100
`define RV_F3_SR   3'b101
`define RV_F3_OR   3'b110
`define RV_F3_AND  3'b111

// branch conditions kept
`define RV_F3_BEQ 3'b000
`define RV_F3_BNE 3'b001

// addi x0, x0, 0
`define RV_NOP 32'h0000_0013

`endif

//--- hdl/rv_pkg.sv
`include "rv_consts.svh"

package rv_pkg;

    // instruction formats, msb first
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    // branch offset scattered, bit 0 implied zero
    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one fetched word, six ways to read it
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and
    } alu_op_e;

    // writeback source
    typedef enum logic [1:0] {
        wb_alu,
        wb_mem,
        wb_link
    } wb_sel_e;

    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    alu_src_imm;
        logic    branch;
        logic    jump;
        logic    branch_ne;
        logic    a_sel_pc;
        logic    a_zero;
        wb_sel_e wb_sel;
    } ctrl_t;

    typedef struct packed {
        logic [`RV_ADDR_W+1:0] pc;
        logic [`RV_ADDR_W+1:0] pc_plus4;
        instr_u                instr;
    } if_id_t;

    typedef struct packed {
        ctrl_t                 ctrl;
        alu_op_e               alu_op;
        logic [`RV_ADDR_W+1:0] pc;
        logic [`RV_ADDR_W+1:0] pc_plus4;
        logic [`RV_DATA_W-1:0] rs1_data;
        logic [`RV_DATA_W-1:0] rs2_data;
        logic [`RV_DATA_W-1:0] imm;
        logic [4:0]            rd;
    } id_ex_t;

    typedef struct packed {
        ctrl_t                 ctrl;
        logic [`RV_DATA_W-1:0] alu_result;
        logic                  zero;
        logic [`RV_ADDR_W+1:0] target;
        logic [`RV_ADDR_W+1:0] pc_plus4;
        logic [`RV_DATA_W-1:0] rs2_data;
        logic [4:0]            rd;
    } ex_mem_t;

    typedef struct packed {
        logic                  reg_write;
        wb_sel_e               wb_sel;
        logic [`RV_DATA_W-1:0] alu_result;
        logic [`RV_DATA_W-1:0] load_data;
        logic [`RV_ADDR_W+1:0] pc_plus4;
        logic [4:0]            rd;
    } mem_wb_t;

endpackage

//--- hdl/rv_decode.sv
`include "rv_consts.svh"

module rv_decode
    import rv_pkg::*;
(
    input  instr_u                instr,
    output ctrl_t                 ctrl,
    output alu_op_e               alu_op,
    output logic [`RV_DATA_W-1:0] imm
);

    // funct3 plus bit 30 to alu operation
    function automatic alu_op_e funct_op(input logic [2:0] funct3, input logic alt);
        alu_op_e op;
        case (funct3)
            `RV_F3_ADD:  op = alt ? alu_sub : alu_add;
            `RV_F3_SLL:  op = alu_sll;
            `RV_F3_SLT:  op = alu_slt;
            `RV_F3_SLTU: op = alu_sltu;
            `RV_F3_XOR:  op = alu_xor;
            `RV_F3_SR:   op = alt ? alu_sra : alu_srl;
            `RV_F3_OR:   op = alu_or;
            default:     op = alu_and;
        endcase
        return op;
    endfunction

    always_comb begin
        // unknown opcode falls through as a bubble
        ctrl   = '0;
        alu_op = alu_add;
        imm    = '0;
        case (instr.r.opcode)
            `RV_OP_OP: begin
                ctrl.reg_write = 1'b1;
                alu_op         = funct_op(instr.r.funct3, instr.r.funct7[5]);
            end
            `RV_OP_OP_IMM: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                // bit 30 only selects sra here, no subi
                alu_op = funct_op(instr.i.funct3,
                                  instr.i.funct3 == `RV_F3_SR && instr.r.funct7[5]);
                imm    = {{20{instr.i.imm[11]}}, instr.i.imm};
            end
            `RV_OP_LOAD: begin
                ctrl.reg_write   = 1'b1;
                ctrl.mem_read    = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.wb_sel      = wb_mem;
                imm = {{20{instr.i.imm[11]}}, instr.i.imm};
            end
            `RV_OP_STORE: begin
                ctrl.mem_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                imm = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
            end
            `RV_OP_BRANCH: begin
                // only beq and bne, compare by subtraction
                ctrl.branch    = instr.b.funct3 == `RV_F3_BEQ || instr.b.funct3 == `RV_F3_BNE;
                ctrl.branch_ne = instr.b.funct3 == `RV_F3_BNE;
                alu_op         = alu_sub;
                imm = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
                       instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
            end
            `RV_OP_JAL: begin
                ctrl.reg_write = 1'b1;
                ctrl.jump      = 1'b1;
                ctrl.wb_sel    = wb_link;
                imm = {{11{instr.j.imm_20}}, instr.j.imm_20, instr.j.imm_19_12,
                       instr.j.imm_11, instr.j.imm_10_1, 1'b0};
            end
            `RV_OP_LUI, `RV_OP_AUIPC: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                // lui adds to zero, auipc to the pc
                ctrl.a_zero      = instr.u.opcode == `RV_OP_LUI;
                ctrl.a_sel_pc    = instr.u.opcode == `RV_OP_AUIPC;
                imm = {instr.u.imm_31_12, 12'b0};
            end
            default: ;
        endcase
    end

endmodule

//--- hdl/rv_alu.sv
`include "rv_consts.svh"

module rv_alu
    import rv_pkg::*;
(
    input  logic [`RV_DATA_W-1:0] a,
    input  logic [`RV_DATA_W-1:0] b,
    input  alu_op_e               op,
    output logic [`RV_DATA_W-1:0] result,
    output logic                  zero
);

    always_comb begin
        result = '0;
        case (op)
            alu_add:  result = a + b;
            alu_sub:  result = a - b;
            // shifts take the low five bits only
            alu_sll:  result = a << b[4:0];
            alu_srl:  result = a >> b[4:0];
            alu_sra:  result = $signed(a) >>> b[4:0];
            // set-less-than yields 0 or 1
            alu_slt:  result[0] = $signed(a) < $signed(b);
            alu_sltu: result[0] = a < b;
            alu_xor:  result = a ^ b;
            alu_or:   result = a | b;
            alu_and:  result = a & b;
            default:  result = a + b;
        endcase
    end

    // beq and bne decide on this
    assign zero = result == '0;

endmodule

//--- hdl/rv_regfile.sv
`include "rv_consts.svh"

module rv_regfile (
    input  logic                  CLK,
    input  logic                  RESET_N,
    input  logic [4:0]            rs1,
    input  logic [4:0]            rs2,
    input  logic [4:0]            rd,
    input  logic                  we,
    input  logic [`RV_DATA_W-1:0] wdata,
    output logic [`RV_DATA_W-1:0] rs1_data,
    output logic [`RV_DATA_W-1:0] rs2_data
);

    // x0 has no storage
    logic [`RV_DATA_W-1:0] regs [1:31];

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
    end

    // write-through so decode sees this cycle's writeback
    function automatic logic [`RV_DATA_W-1:0] read_port(input logic [4:0] idx);
        if (idx == 5'd0) begin
            return '0;
        end
        if (we && idx == rd) begin
            return wdata;
        end
        return regs[idx];
    endfunction

    always_comb begin
        rs1_data = read_port(rs1);
        rs2_data = read_port(rs2);
    end

endmodule

//--- hdl/rv_core.sv
`include "rv_consts.svh"

module rv_core
    import rv_pkg::*;
(
    input  logic                  CLK,
    input  logic                  RESET_N,
    input  logic                  clear,
    input  logic [`RV_DATA_W-1:0] idata,
    output logic [`RV_ADDR_W-1:0] iaddr,
    output logic [`RV_ADDR_W-1:0] daddr,
    input  logic [`RV_DATA_W-1:0] ddata_r,
    output logic [`RV_DATA_W-1:0] ddata_w,
    output logic                  mem_write,
    output logic                  mem_read
);

    // byte address of the pc
    localparam int PC_W = `RV_ADDR_W + 2;

    // fetch slot bubble, later stages bubble as all zero
    localparam if_id_t if_id_nop = '{pc: '0, pc_plus4: '0, instr: `RV_NOP};

    logic [PC_W-1:0]       pc;
    logic [PC_W-1:0]       pc_plus4;
    if_id_t                if_id, if_id_d;
    id_ex_t                id_ex, id_ex_d;
    ex_mem_t               ex_mem, ex_mem_d;
    mem_wb_t               mem_wb, mem_wb_d;

    ctrl_t                 id_ctrl;
    alu_op_e               id_alu_op;
    logic [`RV_DATA_W-1:0] id_imm;
    logic [`RV_DATA_W-1:0] id_rs1_data;
    logic [`RV_DATA_W-1:0] id_rs2_data;

    logic [`RV_DATA_W-1:0] op_a;
    logic [`RV_DATA_W-1:0] op_b;
    logic [`RV_DATA_W-1:0] ex_result;
    logic                  ex_zero;
    logic                  taken;
    logic [`RV_DATA_W-1:0] wb_data;

    // fetch
    assign pc_plus4 = pc + PC_W'(4);
    assign iaddr    = pc[PC_W-1:2];

    // decode
    rv_decode decode_inst (
        .instr  (if_id.instr),
        .ctrl   (id_ctrl),
        .alu_op (id_alu_op),
        .imm    (id_imm)
    );

    // read in decode, written from the wb register
    rv_regfile regfile_inst (
        .CLK      (CLK),
        .RESET_N  (RESET_N),
        .rs1      (if_id.instr.r.rs1),
        .rs2      (if_id.instr.r.rs2),
        .rd       (mem_wb.rd),
        .we       (mem_wb.reg_write),
        .wdata    (wb_data),
        .rs1_data (id_rs1_data),
        .rs2_data (id_rs2_data)
    );

    // execute, operand a is zero for lui and pc for auipc
    assign op_a = id_ex.ctrl.a_zero   ? '0 :
                  id_ex.ctrl.a_sel_pc ? `RV_DATA_W'(id_ex.pc) : id_ex.rs1_data;
    assign op_b = id_ex.ctrl.alu_src_imm ? id_ex.imm : id_ex.rs2_data;

    rv_alu alu_inst (
        .a      (op_a),
        .b      (op_b),
        .op     (id_ex.alu_op),
        .result (ex_result),
        .zero   (ex_zero)
    );

    // memory stage, branch and jump resolve here
    assign taken = ex_mem.ctrl.jump ||
                   (ex_mem.ctrl.branch && (ex_mem.zero ^ ex_mem.ctrl.branch_ne));

    assign daddr     = ex_mem.alu_result[PC_W-1:2];
    assign ddata_w   = ex_mem.rs2_data;
    assign mem_write = ex_mem.ctrl.mem_write;
    assign mem_read  = ex_mem.ctrl.mem_read;

    // writeback mux
    always_comb begin
        case (mem_wb.wb_sel)
            wb_mem:  wb_data = mem_wb.load_data;
            wb_link: wb_data = `RV_DATA_W'(mem_wb.pc_plus4);
            default: wb_data = mem_wb.alu_result;
        endcase
    end

    // next contents of each pipeline register
    always_comb begin
        if_id_d.pc       = pc;
        if_id_d.pc_plus4 = pc_plus4;
        if_id_d.instr    = idata;

        id_ex_d.ctrl     = id_ctrl;
        id_ex_d.alu_op   = id_alu_op;
        id_ex_d.pc       = if_id.pc;
        id_ex_d.pc_plus4 = if_id.pc_plus4;
        id_ex_d.rs1_data = id_rs1_data;
        id_ex_d.rs2_data = id_rs2_data;
        id_ex_d.imm      = id_imm;
        id_ex_d.rd       = if_id.instr.r.rd;

        ex_mem_d.ctrl       = id_ex.ctrl;
        ex_mem_d.alu_result = ex_result;
        ex_mem_d.zero       = ex_zero;
        // own adder for branch and jal target
        ex_mem_d.target     = id_ex.pc + id_ex.imm[PC_W-1:0];
        ex_mem_d.pc_plus4   = id_ex.pc_plus4;
        ex_mem_d.rs2_data   = id_ex.rs2_data;
        ex_mem_d.rd         = id_ex.rd;

        mem_wb_d.reg_write  = ex_mem.ctrl.reg_write;
        mem_wb_d.wb_sel     = ex_mem.ctrl.wb_sel;
        mem_wb_d.alu_result = ex_mem.alu_result;
        mem_wb_d.load_data  = ddata_r;
        mem_wb_d.pc_plus4   = ex_mem.pc_plus4;
        mem_wb_d.rd         = ex_mem.rd;
    end

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            pc     <= '0;
            if_id  <= if_id_nop;
            id_ex  <= '0;
            ex_mem <= '0;
            mem_wb <= '0;
        end else if (clear) begin
            // flush all four, pc holds so fetch resumes where it was
            if_id  <= if_id_nop;
            id_ex  <= '0;
            ex_mem <= '0;
            mem_wb <= '0;
        end else if (taken) begin
            // redirect and drop the three younger instructions
            pc     <= ex_mem.target;
            if_id  <= if_id_nop;
            id_ex  <= '0;
            ex_mem <= '0;
            mem_wb <= mem_wb_d;
        end else begin
            pc     <= pc_plus4;
            if_id  <= if_id_d;
            id_ex  <= id_ex_d;
            ex_mem <= ex_mem_d;
            mem_wb <= mem_wb_d;
        end
    end

    assert property (@(posedge CLK) disable iff (!RESET_N) !(mem_read && mem_write));

    // first edge out of reset still fetches address 0
    assert property (@(posedge CLK) $rose(RESET_N) |-> iaddr == '0);

endmodule

//--- tb/tb_rv_core.sv
`include "rv_consts.svh"

module tb_rv_core;

    localparam int RESET_CYCLES = 4;
    // byte address of the store area, word 256
    localparam int BASE = 1024;
    localparam int MEM_WORDS = 1 << `RV_ADDR_W;
    // lw reads of the add and sub words
    localparam int N_LOADS = 2;

    logic                  CLK = 1'b0;
    logic                  RESET_N;
    logic                  clear = 1'b0;
    logic [`RV_DATA_W-1:0] idata;
    logic [`RV_ADDR_W-1:0] iaddr;
    logic [`RV_ADDR_W-1:0] daddr;
    logic [`RV_DATA_W-1:0] ddata_r;
    logic [`RV_DATA_W-1:0] ddata_w;
    logic                  mem_write;
    logic                  mem_read;

    logic [`RV_DATA_W-1:0] rom [0:MEM_WORDS-1];
    logic [`RV_DATA_W-1:0] ram [0:MEM_WORDS-1];

    // expected stores in program order
    logic [`RV_ADDR_W-1:0] exp_addr [0:63];
    logic [`RV_DATA_W-1:0] exp_data [0:63];
    string                 exp_name [0:63];

    int n_exp = 0;
    int store_idx = 0;
    int load_idx = 0;
    int lw_store = 0;
    int n_instr = 0;
    int cycles = 0;
    int max_cycles = 0;
    int clear_word = 0;
    int seed;
    bit clear_done = 1'b0;

    always #2 CLK = ~CLK;

    rv_core rv_core_inst (
        .CLK       (CLK),
        .RESET_N   (RESET_N),
        .clear     (clear),
        .idata     (idata),
        .iaddr     (iaddr),
        .daddr     (daddr),
        .ddata_r   (ddata_r),
        .ddata_w   (ddata_w),
        .mem_write (mem_write),
        .mem_read  (mem_read)
    );

    // combinational rom and ram reads, ram writes on the edge
    assign idata   = rom[iaddr];
    assign ddata_r = ram[daddr];

    always @(posedge CLK) begin
        if (!RESET_N) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                ram[i] <= 32'h5a00_0000 | i;
            end
        end else if (mem_write) begin
            ram[daddr] <= ddata_w;
        end
    end

    // instruction encoders
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, `RV_OP_OP};
    endfunction

    function automatic logic [31:0] i_type(input logic [6:0] op, input logic [4:0] rd,
                                           input logic [2:0] f3, input logic [4:0] rs1,
                                           input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    // sw only, funct3 010
    function automatic logic [31:0] s_type(input logic [4:0] rs2, input logic [4:0] rs1,
                                           input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `RV_OP_STORE};
    endfunction

    function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `RV_OP_BRANCH};
    endfunction

    function automatic logic [31:0] u_type(input logic [6:0] op, input logic [4:0] rd,
                                           input logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, `RV_OP_JAL};
    endfunction

    task automatic emit(input logic [31:0] word);
        rom[n_instr] = word;
        n_instr++;
    endtask

    // two constants via lui then addi, spaced for the missing forwarding
    task automatic load_pair(input logic [4:0] rd1, input logic [31:0] v1,
                             input logic [4:0] rd2, input logic [31:0] v2);
        logic [31:0] h1;
        logic [31:0] h2;
        // round up so the signed low part lands back on v
        h1 = v1 + 32'h800;
        h2 = v2 + 32'h800;
        emit(u_type(`RV_OP_LUI, rd1, h1[31:12]));
        emit(u_type(`RV_OP_LUI, rd2, h2[31:12]));
        emit(`RV_NOP);
        emit(i_type(`RV_OP_OP_IMM, rd1, `RV_F3_ADD, rd1, v1[11:0]));
        emit(i_type(`RV_OP_OP_IMM, rd2, `RV_F3_ADD, rd2, v2[11:0]));
    endtask

    // store to the next free word and expect it there
    task automatic store_reg(input logic [4:0] rs2, input string name,
                             input logic [31:0] value);
        emit(s_type(rs2, 5'd1, 12'(4 * n_exp)));
        exp_addr[n_exp] = `RV_ADDR_W'(BASE / 4 + n_exp);
        exp_data[n_exp] = value;
        exp_name[n_exp] = name;
        n_exp++;
    endtask

    // marker stores that a redirect must drop
    task automatic squash_slots();
        for (int i = 0; i < 3; i++) begin
            emit(s_type(5'd31, 5'd1, 12'h7fc));
        end
    endtask

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (RESET_N && mem_write) begin
            store_idx <= store_idx + 1;
        end
        if (RESET_N && mem_read) begin
            load_idx <= load_idx + 1;
        end
    end

    // pulse clear for one cycle once the marker store sits in decode
    always @(negedge CLK) begin
        if (clear) begin
            clear = 1'b0;
        end else if (RESET_N && !clear_done && iaddr == `RV_ADDR_W'(clear_word + 1)) begin
            clear      = 1'b1;
            clear_done = 1'b1;
        end
    end

    always @(negedge CLK) begin
        if (cycles > max_cycles) begin
            $display("Timeout: program did not finish within %0d cycles", max_cycles);
            $display("Result: FAILED");
            $fatal(1, "timeout");
        end
    end

    // quiet data port and fetch at 0 through reset and the first cycle after
    assert property (@(posedge CLK)
        cycles <= RESET_CYCLES |-> iaddr == '0 && !mem_write && !mem_read)
    else begin
        $display("memory port active or fetch address not zero around reset");
        $display("Result: FAILED");
        $fatal(1, "reset state");
    end

    assert property (@(posedge CLK) disable iff (!RESET_N) mem_write |-> store_idx < n_exp)
    else begin
        $display("store to word %0d after the last expected store", $sampled(daddr));
        $display("Result: FAILED");
        $fatal(1, "extra store");
    end

    // each store against the next table entry
    assert property (@(posedge CLK) disable iff (!RESET_N)
        mem_write && store_idx < n_exp |->
        daddr == exp_addr[store_idx] && ddata_w == exp_data[store_idx])
    else begin
        $display("Fail %s: expected word %0d data %h, actual word %0d data %h",
                 exp_name[$sampled(store_idx)], exp_addr[$sampled(store_idx)],
                 exp_data[$sampled(store_idx)], $sampled(daddr), $sampled(ddata_w));
        $display("Result: FAILED");
        $fatal(1, "store mismatch");
    end

    // loads read the add word then the sub word
    assert property (@(posedge CLK) disable iff (!RESET_N)
        mem_read |-> load_idx < N_LOADS && daddr == `RV_ADDR_W'(BASE / 4 + load_idx))
    else begin
        $display("Fail lw: expected word %0d, actual word %0d",
                 BASE / 4 + $sampled(load_idx), $sampled(daddr));
        $display("Result: FAILED");
        $fatal(1, "load mismatch");
    end

    // both loads have raised mem_read by the time their data is stored again
    assert property (@(posedge CLK) disable iff (!RESET_N)
        mem_write && store_idx == lw_store |-> load_idx == N_LOADS)
    else begin
        $display("mem_read was raised for %0d of %0d loads", $sampled(load_idx), N_LOADS);
        $display("Result: FAILED");
        $fatal(1, "missing load");
    end

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sx;
        logic [11:0] imm;
        logic [4:0]  sh;
        logic [19:0] up;
        int          auipc_pc;
        int          jal_pc;
        RESET_N = 1'b0;
        seed    = 32'h927fd7db;
        a   = $random(seed);
        b   = $random(seed);
        imm = 12'($random(seed));
        sh  = 5'($random(seed));
        up  = 20'($random(seed));
        sx  = {{20{imm[11]}}, imm};

        // unused words are addi x0 with the address as immediate
        for (int i = 0; i < MEM_WORDS; i++) begin
            rom[i] = i_type(`RV_OP_OP_IMM, 5'd0, `RV_F3_ADD, 5'd0, 12'(i));
        end

        load_pair(5'd2, a, 5'd3, b);
        load_pair(5'd1, BASE, 5'd31, 32'hdead_beef);

        // register forms, x2 op x3
        emit(r_type(7'h00, `RV_F3_ADD, 5'd4, 5'd2, 5'd3));
        emit(r_type(7'h20, `RV_F3_ADD, 5'd5, 5'd2, 5'd3));
        emit(r_type(7'h00, `RV_F3_SLL, 5'd6, 5'd2, 5'd3));
        emit(r_type(7'h00, `RV_F3_SLT, 5'd7, 5'd2, 5'd3));
        emit(r_type(7'h00, `RV_F3_SLTU, 5'd8, 5'd2, 5'd3));
        emit(r_type(7'h00, `RV_F3_XOR, 5'd9, 5'd2, 5'd3));
        emit(r_type(7'h00, `RV_F3_SR, 5'd10, 5'd2, 5'd3));
        emit(r_type(7'h20, `RV_F3_SR, 5'd11, 5'd2, 5'd3));
        emit(r_type(7'h00, `RV_F3_OR, 5'd12, 5'd2, 5'd3));
        emit(r_type(7'h00, `RV_F3_AND, 5'd13, 5'd2, 5'd3));
        store_reg(5'd4, "add", a + b);
        store_reg(5'd5, "sub", a - b);
        store_reg(5'd6, "sll", a << b[4:0]);
        store_reg(5'd7, "slt", {31'b0, $signed(a) < $signed(b)});
        store_reg(5'd8, "sltu", {31'b0, a < b});
        store_reg(5'd9, "xor", a ^ b);
        store_reg(5'd10, "srl", a >> b[4:0]);
        store_reg(5'd11, "sra", $signed(a) >>> b[4:0]);
        store_reg(5'd12, "or", a | b);
        store_reg(5'd13, "and", a & b);

        // immediate forms on x2
        emit(i_type(`RV_OP_OP_IMM, 5'd14, `RV_F3_ADD, 5'd2, imm));
        emit(i_type(`RV_OP_OP_IMM, 5'd15, `RV_F3_SLT, 5'd2, imm));
        emit(i_type(`RV_OP_OP_IMM, 5'd16, `RV_F3_SLTU, 5'd2, imm));
        emit(i_type(`RV_OP_OP_IMM, 5'd17, `RV_F3_XOR, 5'd2, imm));
        emit(i_type(`RV_OP_OP_IMM, 5'd18, `RV_F3_OR, 5'd2, imm));
        emit(i_type(`RV_OP_OP_IMM, 5'd19, `RV_F3_AND, 5'd2, imm));
        emit(i_type(`RV_OP_OP_IMM, 5'd20, `RV_F3_SLL, 5'd2, {7'h00, sh}));
        emit(i_type(`RV_OP_OP_IMM, 5'd21, `RV_F3_SR, 5'd2, {7'h00, sh}));
        emit(i_type(`RV_OP_OP_IMM, 5'd22, `RV_F3_SR, 5'd2, {7'h20, sh}));
        store_reg(5'd14, "addi", a + sx);
        store_reg(5'd15, "slti", {31'b0, $signed(a) < $signed(sx)});
        store_reg(5'd16, "sltiu", {31'b0, a < sx});
        store_reg(5'd17, "xori", a ^ sx);
        store_reg(5'd18, "ori", a | sx);
        store_reg(5'd19, "andi", a & sx);
        store_reg(5'd20, "slli", a << sh);
        store_reg(5'd21, "srli", a >> sh);
        store_reg(5'd22, "srai", $signed(a) >>> sh);

        // upper immediates, then reload the add and sub words
        emit(u_type(`RV_OP_LUI, 5'd23, up));
        auipc_pc = 4 * n_instr;
        emit(u_type(`RV_OP_AUIPC, 5'd24, up));
        // lw, funct3 010
        emit(i_type(`RV_OP_LOAD, 5'd25, 3'b010, 5'd1, 12'd0));
        emit(i_type(`RV_OP_LOAD, 5'd26, 3'b010, 5'd1, 12'd4));
        store_reg(5'd23, "lui", {up, 12'b0});
        store_reg(5'd24, "auipc", {up, 12'b0} + auipc_pc);
        lw_store = n_exp;
        store_reg(5'd25, "lw_add", a + b);
        store_reg(5'd26, "lw_sub", a - b);

        // branches jump 16 bytes, over three slots
        emit(b_type(`RV_F3_BEQ, 5'd2, 5'd2, 13'd16));
        squash_slots();
        store_reg(5'd2, "beq_taken", a);
        emit(b_type(`RV_F3_BEQ, 5'd1, 5'd0, 13'd16));
        store_reg(5'd4, "beq_fall_0", a + b);
        store_reg(5'd5, "beq_fall_1", a - b);
        store_reg(5'd9, "beq_fall_2", a ^ b);
        emit(b_type(`RV_F3_BNE, 5'd1, 5'd0, 13'd16));
        squash_slots();
        store_reg(5'd3, "bne_taken", b);
        emit(b_type(`RV_F3_BNE, 5'd2, 5'd2, 13'd16));
        store_reg(5'd12, "bne_fall_0", a | b);
        store_reg(5'd13, "bne_fall_1", a & b);
        store_reg(5'd14, "bne_fall_2", a + sx);
        jal_pc = 4 * n_instr;
        emit(j_type(5'd27, 21'd16));
        squash_slots();
        store_reg(5'd27, "jal_link", jal_pc + 4);

        // bubbles in execute and memory when the flush hits
        emit(`RV_NOP);
        emit(`RV_NOP);
        clear_word = n_instr;
        emit(s_type(5'd31, 5'd1, 12'h7fc));
        store_reg(5'd15, "after_clear", {31'b0, $signed(a) < $signed(sx)});
        // park on a jump to itself
        emit(j_type(5'd0, 21'd0));

        // each word at most twice, squash and clear slots included
        max_cycles = RESET_CYCLES + 2 * n_instr + 64;

        repeat (RESET_CYCLES) @(posedge CLK);
        @(negedge CLK);
        RESET_N = 1'b1;

        wait (store_idx == n_exp);
        // drain so a late stray store still hits an assertion
        repeat (8) @(negedge CLK);
        $display("Result: PASSED");
        $finish;
    end

endmodule

//--- flist.f
+incdir+hdl
hdl/rv_pkg.sv
hdl/rv_decode.sv
hdl/rv_alu.sv
hdl/rv_regfile.sv
hdl/rv_core.sv
tb/tb_rv_core.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_rv_core
FLIST      := flist.f
BUILD_DIR  := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only -Wall --timing --assert
SIM_FLAGS  := --binary --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then exit 1; fi
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
